//--- src.f
rtl/imm_pkg.sv
rtl/imm_mixer.sv
rtl/imm_model_filter.sv
rtl/imm_combiner.sv
rtl/imm_tracker_top.sv
sim/imm_tracker_asserts.sv
sim/imm_tracker_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the IMM tracker testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module imm_tracker_tb -f src.f -o imm_tracker_sim

./obj_dir/imm_tracker_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- sim/imm_tracker_tb.sv
`timescale 1ns/1ps

module imm_tracker_tb;

    localparam int TIMEOUT_CYCLES = 60;

    logic                clk;
    logic                rst_n;
    logic                valid_in;
    imm_pkg::vec3_t      meas_pos;
    logic                meas_valid;
    imm_pkg::state_vec_t state_out;
    imm_pkg::prob_t      model_prob [imm_pkg::NUM_MODELS];
    logic                valid_out;

    // Update bookkeeping
    int in_count;
    int out_count;

    // Test bookkeeping
    int tests_run;
    int tests_failed;
    int test_errors;
    int fails_at_start;

    imm_pkg::vec3_t target;

    imm_tracker_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .meas_pos   (meas_pos),
        .meas_valid (meas_valid),
        .state_out  (state_out),
        .model_prob (model_prob),
        .valid_out  (valid_out)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    // Count published updates
    always @(posedge clk) begin
        if (valid_out) begin
            out_count <= out_count + 1;
        end
    end

    // =========================================================================
    // Helpers
    // =========================================================================

    // Total of all assertion failures in the bound checker
    function automatic int assertion_fails();
        return dut0.u_asserts.fail_latency + dut0.u_asserts.fail_single
             + dut0.u_asserts.fail_reset + dut0.u_asserts.fail_prob_sum
             + dut0.u_asserts.fail_no_meas + dut0.u_asserts.fail_converge;
    endfunction

    // Position within about 16 units of the origin on each axis
    function automatic imm_pkg::vec3_t random_vec();
        imm_pkg::vec3_t v;
        v.x = imm_pkg::q16_t'($urandom_range(0, 32'h001F_FFFF)) - 32'sh0010_0000;
        v.y = imm_pkg::q16_t'($urandom_range(0, 32'h001F_FFFF)) - 32'sh0010_0000;
        v.z = imm_pkg::q16_t'($urandom_range(0, 32'h001F_FFFF)) - 32'sh0010_0000;
        return v;
    endfunction

    // One input strobe, starting and ending on a falling edge
    task automatic drive_update(input imm_pkg::vec3_t p, input logic mv);
        valid_in   = 1'b1;
        meas_pos   = p;
        meas_valid = mv;
        @(negedge clk);
        valid_in   = 1'b0;
        in_count++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Wait until every issued update has come out
    task automatic wait_outputs(input string name);
        int cycles;
        cycles = 0;
        while (out_count != in_count && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (out_count != in_count) begin
            $display("%s: timeout, %0d of %0d updates came out within %0d cycles",
                     name, out_count, in_count, TIMEOUT_CYCLES);
            test_errors++;
            in_count = out_count;
        end
    endtask

    // Updates in flight are lost on reset
    task automatic apply_reset(input int n);
        rst_n = 1'b0;
        repeat (n) @(negedge clk);
        rst_n = 1'b1;
        in_count = out_count;
    endtask

    // One line per test
    task automatic end_test(input string name);
        int fails;
        // Checks of the last update land a few edges later
        repeat (3) @(negedge clk);
        fails = assertion_fails() - fails_at_start;
        tests_run++;
        if (fails != 0) begin
            tests_failed++;
            $display("error: %s expected 0 assertion failures, actual %0d", name, fails);
        end else if (test_errors != 0) begin
            tests_failed++;
            $display("%s: failed, %0d waits timed out", name, test_errors);
        end else begin
            $display("%s: ok", name);
        end
        fails_at_start = assertion_fails();
        test_errors    = 0;
    endtask

    // =========================================================================
    // Test sequence
    // =========================================================================
    initial begin
        void'($urandom(42));
        clk            = 1'b0;
        rst_n          = 1'b0;
        valid_in       = 1'b0;
        meas_pos       = '0;
        meas_valid     = 1'b0;
        in_count       = 0;
        out_count      = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_errors    = 0;
        fails_at_start = 0;

        // Power-on reset
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        end_test("reset_values");

        // Single update, then four back to back
        drive_update('0, 1'b0);
        wait_outputs("latency");
        for (int i = 0; i < 4; i++) begin
            drive_update('0, 1'b0);
        end
        wait_outputs("latency");
        end_test("latency");

        // Zero state with no measurement keeps everything still
        for (int i = 0; i < 6; i++) begin
            drive_update(random_vec(), 1'b0);
            wait_outputs("no_measurement");
        end
        end_test("no_measurement");

        // Random measurements with random gaps, some back to back
        for (int i = 0; i < 24; i++) begin
            drive_update(random_vec(), ($urandom_range(0, 3) != 0));
            idle_cycles($urandom_range(0, 4));
        end
        wait_outputs("prob_sum");
        end_test("prob_sum");

        // Fixed target from the zero state
        apply_reset(4);
        target = random_vec();
        for (int i = 0; i < 12; i++) begin
            drive_update(target, 1'b1);
            wait_outputs("convergence");
        end
        end_test("convergence");

        // Reset with updates in flight, then one more update
        for (int i = 0; i < 3; i++) begin
            drive_update(random_vec(), 1'b1);
        end
        idle_cycles(1);
        apply_reset(3);
        drive_update(random_vec(), 1'b1);
        wait_outputs("mid_run_reset");
        end_test("mid_run_reset");

        $display("Summary: %0d tests, %0d failed, %0d assertion failures",
                 tests_run, tests_failed, assertion_fails());
        if (tests_failed == 0 && assertion_fails() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- sim/imm_tracker_asserts.sv
`timescale 1ns/1ps

module imm_tracker_asserts (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 valid_in,
    input imm_pkg::vec3_t       meas_pos,
    input logic                 meas_valid,
    input imm_pkg::state_vec_t  state_out,
    input imm_pkg::prob_t       model_prob [imm_pkg::NUM_MODELS],
    input logic                 valid_out
);

    // Failure counts, one per property
    int fail_latency  = 0;
    int fail_single   = 0;
    int fail_reset    = 0;
    int fail_prob_sum = 0;
    int fail_no_meas  = 0;
    int fail_converge = 0;

    // Shadow of the four-cycle update pipeline
    logic [3:0]     in_pipe;
    logic [3:0]     no_meas_pipe;
    logic [3:0]     conv_pipe;
    imm_pkg::vec3_t target_pipe [4];
    imm_pkg::vec3_t start_pipe [4];

    logic        quiet;
    logic        probs_init;
    logic        zero_motion;
    logic [17:0] prob_sum;
    logic        conv_ok;

    // Distance to the target on one axis at least halves, 8 LSB slack, no overshoot
    function automatic logic axis_halves(imm_pkg::q16_t target, imm_pkg::q16_t start,
                                         imm_pkg::q16_t now);
        logic signed [63:0] d_old;
        logic signed [63:0] d_new;
        logic signed [63:0] a_old;
        logic signed [63:0] a_new;
        logic               same_side;
        d_old     = 64'(target) - 64'(start);
        d_new     = 64'(target) - 64'(now);
        a_old     = (d_old < 0) ? -d_old : d_old;
        a_new     = (d_new < 0) ? -d_new : d_new;
        same_side = (d_new == 0) || ((d_new < 0) == (d_old < 0));
        if (d_old == 0) begin
            return d_new == 0;
        end
        return same_side && (2 * a_new <= a_old + 16);
    endfunction

    // =========================================================================
    // Reference bookkeeping
    // =========================================================================
    always_comb begin
        // No update started in the last three cycles, so the prior is settled
        quiet       = (in_pipe[2:0] == 3'b000);
        zero_motion = (state_out.vel == '0) && (state_out.acc == '0);
        probs_init  = 1'b1;
        prob_sum    = '0;
        for (int m = 0; m < imm_pkg::NUM_MODELS; m++) begin
            probs_init = probs_init && (model_prob[m] == imm_pkg::MU_INIT);
            prob_sum   = prob_sum + 18'(model_prob[m]);
        end
        conv_ok = zero_motion
               && axis_halves(target_pipe[3].x, start_pipe[3].x, state_out.pos.x)
               && axis_halves(target_pipe[3].y, start_pipe[3].y, state_out.pos.y)
               && axis_halves(target_pipe[3].z, start_pipe[3].z, state_out.pos.z);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pipe      <= '0;
            no_meas_pipe <= '0;
            conv_pipe    <= '0;
        end else begin
            in_pipe      <= {in_pipe[2:0], valid_in};
            no_meas_pipe <= {no_meas_pipe[2:0],
                             valid_in && !meas_valid && quiet && (state_out == '0) && probs_init};
            conv_pipe    <= {conv_pipe[2:0],
                             valid_in && meas_valid && quiet && zero_motion && probs_init};
        end
    end

    // Target and starting position of each update
    always_ff @(posedge clk) begin
        target_pipe[0] <= meas_pos;
        start_pipe[0]  <= state_out.pos;
        for (int i = 1; i < 4; i++) begin
            target_pipe[i] <= target_pipe[i-1];
            start_pipe[i]  <= start_pipe[i-1];
        end
    end

    // =========================================================================
    // Properties
    // =========================================================================
    a_latency : assert property (@(posedge clk) disable iff (!rst_n)
        in_pipe[3] |-> valid_out)
    else begin
        fail_latency = fail_latency + 1;
        $error("latency: expected valid_out 1 four cycles after valid_in, actual 0");
    end

    a_single : assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> in_pipe[3])
    else begin
        fail_single = fail_single + 1;
        $error("single pulse: valid_out high with no valid_in four cycles before");
    end

    a_reset : assert property (@(posedge clk)
        $rose(rst_n) |-> (!valid_out && (state_out == '0) && probs_init))
    else begin
        fail_reset = fail_reset + 1;
        $error("reset: expected valid_out 0 state 0 prob0 4000, actual %0b %h %h",
               valid_out, state_out, model_prob[0]);
    end

    a_prob_sum : assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> ((prob_sum <= 18'h1_0000) && (prob_sum >= 18'h0_FFF0)))
    else begin
        fail_prob_sum = fail_prob_sum + 1;
        $error("prob sum: expected 0fff0 to 10000, actual %h", prob_sum);
    end

    a_no_meas : assert property (@(posedge clk) disable iff (!rst_n)
        (valid_out && no_meas_pipe[3]) |-> ((state_out == '0) && probs_init))
    else begin
        fail_no_meas = fail_no_meas + 1;
        $error("no measurement: expected state 0 prob0 4000, actual %h %h",
               state_out, model_prob[0]);
    end

    a_converge : assert property (@(posedge clk) disable iff (!rst_n)
        (valid_out && conv_pipe[3]) |-> conv_ok)
    else begin
        fail_converge = fail_converge + 1;
        $error("convergence: target %h start %h, actual state %h",
               target_pipe[3], start_pipe[3], state_out);
    end

endmodule

bind imm_tracker_top imm_tracker_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_in   (valid_in),
    .meas_pos   (meas_pos),
    .meas_valid (meas_valid),
    .state_out  (state_out),
    .model_prob (model_prob),
    .valid_out  (valid_out)
);

//--- rtl/imm_tracker_top.sv
`timescale 1ns/1ps

module imm_tracker_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  imm_pkg::vec3_t       meas_pos,
    input  logic                 meas_valid,
    output imm_pkg::state_vec_t  state_out,
    output imm_pkg::prob_t       model_prob [imm_pkg::NUM_MODELS],
    output logic                 valid_out
);

    // Mixer to filters
    imm_pkg::state_vec_t mix_state;
    imm_pkg::vec3_t      mix_meas;
    logic                mix_meas_valid;
    logic                mix_strobe;

    // Filters to combiner
    imm_pkg::model_out_t             filt_out [imm_pkg::NUM_MODELS];
    logic [imm_pkg::NUM_MODELS-1:0]  filt_done;

    // Combiner back to mixer
    imm_pkg::state_vec_t fused_state;

    // =========================================================================
    // Mixer
    // =========================================================================
    imm_mixer u_mixer (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_in       (valid_in),
        .meas_pos       (meas_pos),
        .meas_valid     (meas_valid),
        .fused_state    (fused_state),
        .mix_state      (mix_state),
        .mix_meas       (mix_meas),
        .mix_meas_valid (mix_meas_valid),
        .mix_strobe     (mix_strobe)
    );

    // =========================================================================
    // Model filters, kind follows the index
    // =========================================================================
    for (genvar g = 0; g < imm_pkg::NUM_MODELS; g++) begin : g_model
        imm_model_filter #(
            .KIND (imm_pkg::model_kind_t'(g))
        ) u_filter (
            .clk            (clk),
            .rst_n          (rst_n),
            .mix_state      (mix_state),
            .mix_meas       (mix_meas),
            .mix_meas_valid (mix_meas_valid),
            .mix_strobe     (mix_strobe),
            .model_out      (filt_out[g]),
            .done           (filt_done[g])
        );
    end

    // =========================================================================
    // Combiner
    // =========================================================================

    // Filters run in lockstep so filter 0 paces the combiner
    imm_combiner u_combiner (
        .clk            (clk),
        .rst_n          (rst_n),
        .model_out      (filt_out),
        .done           (filt_done[0]),
        .mix_meas       (mix_meas),
        .mix_meas_valid (mix_meas_valid),
        .fused_state    (fused_state),
        .state_out      (state_out),
        .model_prob     (model_prob),
        .valid_out      (valid_out)
    );

endmodule

//--- rtl/imm_combiner.sv
`timescale 1ns/1ps

module imm_combiner (
    input  logic                 clk,
    input  logic                 rst_n,
    input  imm_pkg::model_out_t  model_out [imm_pkg::NUM_MODELS],
    input  logic                 done,
    input  imm_pkg::vec3_t       mix_meas,
    input  logic                 mix_meas_valid,
    output imm_pkg::state_vec_t  fused_state,
    output imm_pkg::state_vec_t  state_out,
    output imm_pkg::prob_t       model_prob [imm_pkg::NUM_MODELS],
    output logic                 valid_out
);

    // Measurement copy aligned with the two filter stages
    imm_pkg::vec3_t meas_d1;
    imm_pkg::vec3_t meas_d2;
    logic           meas_valid_d1;
    logic           meas_valid_d2;

    // Probability update
    logic [31:0]    prior;
    logic [31:0]    w [imm_pkg::NUM_MODELS];
    logic [33:0]    w_sum;
    logic [47:0]    quot;
    imm_pkg::prob_t mu_new [imm_pkg::NUM_MODELS];

    // Weighted fusion, the state seen as nine flat coordinates
    imm_pkg::q16_t [imm_pkg::STATE_COORDS-1:0] pred_flat [imm_pkg::NUM_MODELS];
    imm_pkg::q16_t [imm_pkg::STATE_COORDS-1:0] fused_flat;
    logic signed [63:0]  acc;
    imm_pkg::state_vec_t fused_next;

    // Pull a position toward the measurement by the fixed gain
    function automatic imm_pkg::vec3_t vec_pull(imm_pkg::vec3_t p, imm_pkg::vec3_t m);
        imm_pkg::vec3_t r;
        r.x = p.x + ((m.x - p.x) >>> imm_pkg::GAIN_SHIFT);
        r.y = p.y + ((m.y - p.y) >>> imm_pkg::GAIN_SHIFT);
        r.z = p.z + ((m.z - p.z) >>> imm_pkg::GAIN_SHIFT);
        return r;
    endfunction

    // =========================================================================
    // Measurement delay line
    // =========================================================================
    always_ff @(posedge clk) begin
        meas_d1 <= mix_meas;
        meas_d2 <= meas_d1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meas_valid_d1 <= 1'b0;
            meas_valid_d2 <= 1'b0;
        end else begin
            meas_valid_d1 <= mix_meas_valid;
            meas_valid_d2 <= meas_valid_d1;
        end
    end

    // =========================================================================
    // Model probabilities
    // =========================================================================
    always_comb begin
        w_sum = '0;
        for (int m = 0; m < imm_pkg::NUM_MODELS; m++) begin
            // Prior times stay probability, then times likelihood
            prior = (32'(model_prob[m]) * 32'(imm_pkg::P_STAY)) >> 16;
            w[m]  = 32'((48'(model_out[m].lik) * 48'(prior[15:0])) >> 16);
            w_sum = w_sum + 34'(w[m]);
        end
        for (int m = 0; m < imm_pkg::NUM_MODELS; m++) begin
            quot = '0;
            if (w_sum != '0) begin
                quot = {w[m], 16'h0000} / 48'(w_sum);
                // A single surviving model would reach 0x10000
                mu_new[m] = (quot > 48'h0000_0000_FFFF) ? 16'hFFFF : quot[15:0];
            end else begin
                // Nothing to normalize, keep the old split
                mu_new[m] = model_prob[m];
            end
        end
    end

    // =========================================================================
    // Weighted state and position correction
    // =========================================================================
    always_comb begin
        for (int m = 0; m < imm_pkg::NUM_MODELS; m++) begin
            pred_flat[m] = model_out[m].pred;
        end
        for (int c = 0; c < imm_pkg::STATE_COORDS; c++) begin
            acc = '0;
            // One shift after the sum keeps equal predictions exact
            for (int m = 0; m < imm_pkg::NUM_MODELS; m++) begin
                acc = acc + $signed(pred_flat[m][c]) * $signed({1'b0, mu_new[m]});
            end
            fused_flat[c] = acc[47:16];
        end
        fused_next = fused_flat;
        if (meas_valid_d2) begin
            fused_next.pos = vec_pull(fused_next.pos, meas_d2);
        end
    end

    // Published results, held between updates
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_out <= '0;
            valid_out <= 1'b0;
            for (int m = 0; m < imm_pkg::NUM_MODELS; m++) begin
                model_prob[m] <= imm_pkg::MU_INIT;
            end
        end else begin
            valid_out <= done;
            if (done) begin
                state_out  <= fused_next;
                model_prob <= mu_new;
            end
        end
    end

    // Feedback to the mixer is the published state itself
    assign fused_state = state_out;

endmodule

//--- rtl/imm_model_filter.sv
`timescale 1ns/1ps

module imm_model_filter #(
    parameter imm_pkg::model_kind_t KIND = imm_pkg::MODEL_CV
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  imm_pkg::state_vec_t  mix_state,
    input  imm_pkg::vec3_t       mix_meas,
    input  logic                 mix_meas_valid,
    input  logic                 mix_strobe,
    output imm_pkg::model_out_t  model_out,
    output logic                 done
);

    // Stage 1 registers
    imm_pkg::state_vec_t pred_q;
    imm_pkg::vec3_t      meas_q;
    logic                meas_valid_q;
    logic                s1_valid;

    // Stage 2 combinational likelihood
    logic [63:0] res_sq;
    logic [63:0] lik_den;
    logic [31:0] lik_c;

    // a + b * k on each axis
    function automatic imm_pkg::vec3_t vec_mac(imm_pkg::vec3_t a, imm_pkg::vec3_t b,
                                               imm_pkg::q16_t k);
        imm_pkg::vec3_t r;
        r.x = a.x + imm_pkg::q_mul_shr(b.x, k, 16);
        r.y = a.y + imm_pkg::q_mul_shr(b.y, k, 16);
        r.z = a.z + imm_pkg::q_mul_shr(b.z, k, 16);
        return r;
    endfunction

    // Squared distance in Q16.16, kept wide so large residuals do not wrap
    function automatic logic [63:0] sq_dist(imm_pkg::vec3_t m, imm_pkg::vec3_t p);
        imm_pkg::q16_t      dx;
        imm_pkg::q16_t      dy;
        imm_pkg::q16_t      dz;
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        logic signed [63:0] sz;
        dx = m.x - p.x;
        dy = m.y - p.y;
        dz = m.z - p.z;
        sx = dx * dx;
        sy = dy * dy;
        sz = dz * dz;
        return ($unsigned(sx) + $unsigned(sy) + $unsigned(sz)) >> 16;
    endfunction

    // =========================================================================
    // Kinematic prediction of this model
    // =========================================================================
    function automatic imm_pkg::state_vec_t predict(imm_pkg::state_vec_t s);
        imm_pkg::state_vec_t p;
        p = s;
        case (KIND)
            imm_pkg::MODEL_CV: begin
                // Constant velocity drops the acceleration
                p.pos = vec_mac(s.pos, s.vel, imm_pkg::DT);
                p.acc = '0;
            end
            imm_pkg::MODEL_CT: begin
                p.pos = vec_mac(s.pos, s.vel, imm_pkg::DT);
                // Small rotation of the horizontal velocity
                p.vel.x = s.vel.x - imm_pkg::q_mul_shr(s.vel.y, imm_pkg::DT,
                                                       imm_pkg::CT_ROT_SHIFT);
                p.vel.y = s.vel.y + imm_pkg::q_mul_shr(s.vel.x, imm_pkg::DT,
                                                       imm_pkg::CT_ROT_SHIFT);
            end
            default: begin
                // CA and jerk share the second-order propagation
                p.pos = vec_mac(vec_mac(s.pos, s.vel, imm_pkg::DT), s.acc,
                                imm_pkg::DT_SQ_HALF);
                p.vel = vec_mac(s.vel, s.acc, imm_pkg::DT);
                if (KIND == imm_pkg::MODEL_JERK) begin
                    p.acc.x = s.acc.x + (s.acc.x >>> imm_pkg::JERK_SHIFT);
                    p.acc.y = s.acc.y + (s.acc.y >>> imm_pkg::JERK_SHIFT);
                    p.acc.z = s.acc.z + (s.acc.z >>> imm_pkg::JERK_SHIFT);
                end
            end
        endcase
        return p;
    endfunction

    // =========================================================================
    // Stage 1 prediction
    // =========================================================================
    always_ff @(posedge clk) begin
        if (mix_strobe) begin
            pred_q <= predict(mix_state);
            meas_q <= mix_meas;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            meas_valid_q <= 1'b0;
            done         <= 1'b0;
        end else begin
            s1_valid <= mix_strobe;
            done     <= s1_valid;
            if (mix_strobe) begin
                meas_valid_q <= mix_meas_valid;
            end
        end
    end

    // =========================================================================
    // Stage 2 likelihood
    // =========================================================================

    // Likelihood ~ 1 / (1 + r^2), about 1.0 at zero residual
    always_comb begin
        res_sq  = sq_dist(meas_q, pred_q.pos);
        lik_den = res_sq + 64'h0000_0000_0001_0000;
        lik_c   = 32'({32'h0, imm_pkg::LIK_NUM} / lik_den);
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            model_out.pred <= pred_q;
            model_out.lik  <= meas_valid_q ? lik_c : imm_pkg::LIK_PRIOR;
        end
    end

endmodule

//--- rtl/imm_mixer.sv
`timescale 1ns/1ps

module imm_mixer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  imm_pkg::vec3_t       meas_pos,
    input  logic                 meas_valid,
    input  imm_pkg::state_vec_t  fused_state,
    output imm_pkg::state_vec_t  mix_state,
    output imm_pkg::vec3_t       mix_meas,
    output logic                 mix_meas_valid,
    output logic                 mix_strobe
);

    // =========================================================================
    // Update capture
    // =========================================================================

    // Simplified mixing
    // Every model restarts from the last published fused state
    // The state is captured at the same edge as the measurement, so an
    // update in flight keeps the prior it started with
    always_ff @(posedge clk) begin
        if (valid_in) begin
            mix_state <= fused_state;
            mix_meas  <= meas_pos;
        end
    end

    // Measurement flag and model start strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mix_meas_valid <= 1'b0;
            mix_strobe     <= 1'b0;
        end else begin
            // Strobe lasts exactly one cycle per accepted input
            mix_strobe <= valid_in;
            if (valid_in) begin
                mix_meas_valid <= meas_valid;
            end
        end
    end

    // Measurement and flag stay held between updates
    // The combiner delay line samples them every cycle and relies on that

endmodule

//--- rtl/imm_pkg.sv
package imm_pkg;

    // =========================================================================
    // Fixed-point types
    // =========================================================================

    // Q16.16 signed value, used for every coordinate
    typedef logic signed [31:0] q16_t;

    // Probability where 0x10000 would be 1.0
    // Held in 16 bits so it saturates at 0xFFFF
    typedef logic [15:0] prob_t;

    typedef struct packed {
        q16_t x;
        q16_t y;
        q16_t z;
    } vec3_t;

    // Full kinematic state, 288 bits
    typedef struct packed {
        vec3_t pos;
        vec3_t vel;
        vec3_t acc;
    } state_vec_t;

    typedef enum logic [1:0] {
        MODEL_CV   = 2'd0,
        MODEL_CA   = 2'd1,
        MODEL_CT   = 2'd2,
        MODEL_JERK = 2'd3
    } model_kind_t;

    // Per-model result handed to the combiner
    typedef struct packed {
        state_vec_t  pred;
        logic [31:0] lik;
    } model_out_t;

    // =========================================================================
    // Filter constants
    // =========================================================================
    localparam int NUM_MODELS   = 4;
    localparam int STATE_COORDS = 9;

    // Sample interval 0.0625 and half its square
    localparam q16_t DT         = 32'sh0000_1000;
    localparam q16_t DT_SQ_HALF = 32'sh0000_0080;

    // Small-angle turn and jerk growth shifts
    localparam int CT_ROT_SHIFT = 20;
    localparam int JERK_SHIFT   = 6;

    // Model probabilities
    localparam prob_t P_STAY  = 16'h0CCC;
    localparam prob_t MU_INIT = 16'h4000;

    // Likelihood numerator and the value used without a measurement
    localparam logic [31:0] LIK_PRIOR = 32'h0001_0000;
    localparam logic [31:0] LIK_NUM   = 32'hFFFF_FFFF;

    // Position correction gain of one half
    localparam int GAIN_SHIFT = 1;

    // Signed product with a right shift, 16 gives a plain Q16.16 multiply
    function automatic q16_t q_mul_shr(q16_t a, q16_t b, int unsigned sh);
        logic signed [63:0] prod;
        prod = a * b;
        prod = prod >>> sh;
        return prod[31:0];
    endfunction

endpackage
